// File: hdl/rv_decode_pkg.sv
package rv_decode_pkg;

    localparam int xlen            = 32;
    localparam int reg_count       = 32;
    localparam int reg_index_width = 5;

    // format codes with none_type for an illegal encoding
    typedef enum logic [2:0] {
        i_type    = 3'd0,
        b_type    = 3'd1,
        s_type    = 3'd2,
        u_type    = 3'd3,
        j_type    = 3'd4,
        r_type    = 3'd5,
        none_type = 3'd7
    } inst_type_t;

    // instr[6:2] per major opcode
    localparam logic [4:0] op_load      = 5'b00000;
    localparam logic [4:0] op_load_fp   = 5'b00001;
    localparam logic [4:0] op_op_imm    = 5'b00100;
    localparam logic [4:0] op_op_imm_32 = 5'b00110;
    localparam logic [4:0] op_jalr      = 5'b11001;
    localparam logic [4:0] op_branch    = 5'b11000;
    localparam logic [4:0] op_op        = 5'b01100;
    localparam logic [4:0] op_op_fp     = 5'b10100;
    localparam logic [4:0] op_store     = 5'b01000;
    localparam logic [4:0] op_store_fp  = 5'b01001;
    localparam logic [4:0] op_auipc     = 5'b00101;
    localparam logic [4:0] op_lui       = 5'b01101;
    localparam logic [4:0] op_jal       = 5'b11011;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // six views of one instruction word
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instruction_t;

endpackage

// File: hdl/decode_fields_if.sv
`timescale 1ns/1ps

interface decode_fields_if;
    import rv_decode_pkg::*;

    inst_type_t                 inst_type;
    logic [6:0]                 opcode;
    logic [2:0]                 funct3;
    logic [6:0]                 funct7;
    logic [reg_index_width-1:0] rs1;
    logic [reg_index_width-1:0] rs2;
    logic [reg_index_width-1:0] rd;
    logic                       illegal;

    // decoder drives everything
    modport producer (
        output inst_type, opcode, funct3, funct7, rs1, rs2, rd, illegal
    );

    modport consumer (
        input inst_type, opcode, funct3, funct7, rs1, rs2, rd, illegal
    );

endinterface

// File: hdl/instruction_decoder.sv
`timescale 1ns/1ps

module instruction_decoder (
    input  rv_decode_pkg::instruction_t instr,
    decode_fields_if.producer           fields
);
    import rv_decode_pkg::*;

    logic [4:0] op_field;
    logic       low_bits_ok;
    logic       is_i;
    logic       is_b;
    logic       is_s;
    logic       is_u;
    logic       is_j;
    logic       is_r;

    assign op_field    = instr.r_fmt.opcode[6:2];
    assign low_bits_ok = (instr.r_fmt.opcode[1:0] == 2'b11);

    assign is_i = (op_field == op_load)
               || (op_field == op_load_fp)
               || (op_field == op_op_imm)
               || (op_field == op_op_imm_32)
               || (op_field == op_jalr);

    assign is_b = (op_field == op_branch);

    assign is_s = (op_field == op_store) || (op_field == op_store_fp);

    assign is_u = (op_field == op_auipc) || (op_field == op_lui);

    assign is_j = (op_field == op_jal);

    assign is_r = (op_field == op_op) || (op_field == op_op_fp);

    // priority i, b, s, u, j, r
    always_comb begin
        if (!low_bits_ok) begin
            fields.inst_type = none_type;
        end else if (is_i) begin
            fields.inst_type = i_type;
        end else if (is_b) begin
            fields.inst_type = b_type;
        end else if (is_s) begin
            fields.inst_type = s_type;
        end else if (is_u) begin
            fields.inst_type = u_type;
        end else if (is_j) begin
            fields.inst_type = j_type;
        end else if (is_r) begin
            fields.inst_type = r_type;
        end else begin
            fields.inst_type = none_type;
        end
    end

    assign fields.illegal = !low_bits_ok || !(is_i || is_b || is_s || is_u || is_j || is_r);

    // raw fields pass through even when illegal
    assign fields.opcode = instr.r_fmt.opcode;
    assign fields.funct3 = instr.r_fmt.funct3;
    assign fields.funct7 = instr.r_fmt.funct7;
    assign fields.rs1    = instr.r_fmt.rs1;
    assign fields.rs2    = instr.r_fmt.rs2;
    assign fields.rd     = instr.r_fmt.rd;

    always_comb begin
        assert final (fields.illegal == (fields.inst_type == none_type))
            else $error("illegal flag disagrees with decoded type");
    end

endmodule

// File: hdl/immediate_generator.sv
`timescale 1ns/1ps

module immediate_generator (
    input  rv_decode_pkg::instruction_t   instr,
    decode_fields_if.consumer             fields,
    output logic [rv_decode_pkg::xlen-1:0] imm
);
    import rv_decode_pkg::*;

    always_comb begin
        case (fields.inst_type)
            i_type: begin
                imm = {{20{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
            end
            s_type: begin
                imm = {{20{instr.s_fmt.imm_11_5[6]}},
                       instr.s_fmt.imm_11_5,
                       instr.s_fmt.imm_4_0};
            end
            b_type: begin
                imm = {{19{instr.b_fmt.imm_12}},
                       instr.b_fmt.imm_12,
                       instr.b_fmt.imm_11,
                       instr.b_fmt.imm_10_5,
                       instr.b_fmt.imm_4_1,
                       1'b0};
            end
            // upper immediate needs no sign extension
            u_type: begin
                imm = {instr.u_fmt.imm_31_12, 12'b0};
            end
            j_type: begin
                imm = {{11{instr.j_fmt.imm_20}},
                       instr.j_fmt.imm_20,
                       instr.j_fmt.imm_19_12,
                       instr.j_fmt.imm_11,
                       instr.j_fmt.imm_10_1,
                       1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

    always_comb begin
        assert final (fields.inst_type != u_type || imm[11:0] == 12'b0)
            else $error("u-type immediate has nonzero low bits");
    end

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic                                     clk,
    input  logic                                     rst,
    decode_fields_if.consumer                        fields,
    input  logic                                     wb_en,
    input  logic [rv_decode_pkg::reg_index_width-1:0] wb_index,
    input  logic [rv_decode_pkg::xlen-1:0]            wb_data,
    output logic [rv_decode_pkg::xlen-1:0]            rs1_data,
    output logic [rv_decode_pkg::xlen-1:0]            rs2_data
);
    import rv_decode_pkg::*;

    // x0 has no storage
    logic [xlen-1:0] regs [1:reg_count-1];
    logic            wb_active;

    assign wb_active = wb_en && (wb_index != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_active) begin
            regs[wb_index] <= wb_data;
        end
    end

    // write-through so a same-edge write is seen by the reader
    always_comb begin
        if (fields.rs1 == '0) begin
            rs1_data = '0;
        end else if (wb_active && (wb_index == fields.rs1)) begin
            rs1_data = wb_data;
        end else begin
            rs1_data = regs[fields.rs1];
        end
    end

    always_comb begin
        if (fields.rs2 == '0) begin
            rs2_data = '0;
        end else if (wb_active && (wb_index == fields.rs2)) begin
            rs2_data = wb_data;
        end else begin
            rs2_data = regs[fields.rs2];
        end
    end

    a_x0_reads_zero: assert property (
        @(posedge clk) disable iff (rst)
        (fields.rs1 == '0) |-> (rs1_data == '0)
    ) else $error("x0 read returned nonzero data");

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                                      clk,
    input  logic                                      rst,

    input  logic                                      instr_valid,
    output logic                                      instr_ready,
    input  logic [rv_decode_pkg::xlen-1:0]            instr,

    input  logic                                      wb_en,
    input  logic [rv_decode_pkg::reg_index_width-1:0] wb_index,
    input  logic [rv_decode_pkg::xlen-1:0]            wb_data,

    output logic                                      out_valid,
    input  logic                                      out_ready,
    output logic [2:0]                                out_type,
    output logic [6:0]                                out_opcode,
    output logic [2:0]                                out_funct3,
    output logic [6:0]                                out_funct7,
    output logic [rv_decode_pkg::reg_index_width-1:0] out_rd,
    output logic [rv_decode_pkg::xlen-1:0]            out_rs1_data,
    output logic [rv_decode_pkg::xlen-1:0]            out_rs2_data,
    output logic [rv_decode_pkg::xlen-1:0]            out_imm,
    output logic                                      out_illegal
);
    import rv_decode_pkg::*;

    instruction_t    instr_word;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic            accept;

    decode_fields_if fields ();

    assign instr_word = instr;

    instruction_decoder i_instruction_decoder (
        .instr  (instr_word),
        .fields (fields.producer)
    );

    immediate_generator i_immediate_generator (
        .instr  (instr_word),
        .fields (fields.consumer),
        .imm    (imm)
    );

    register_file i_register_file (
        .clk      (clk),
        .rst      (rst),
        .fields   (fields.consumer),
        .wb_en    (wb_en),
        .wb_index (wb_index),
        .wb_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // slot frees up on the same edge it drains
    assign instr_ready = !out_valid || out_ready;
    assign accept      = instr_valid && instr_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (instr_ready) begin
            out_valid <= instr_valid;
        end
    end

    // payload only moves on an accepted instruction
    always_ff @(posedge clk) begin
        if (accept) begin
            out_type     <= fields.inst_type;
            out_opcode   <= fields.opcode;
            out_funct3   <= fields.funct3;
            out_funct7   <= fields.funct7;
            out_rd       <= fields.rd;
            out_rs1_data <= rs1_data;
            out_rs2_data <= rs2_data;
            out_imm      <= imm;
            out_illegal  <= fields.illegal;
        end
    end

    a_hold_under_stall: assert property (
        @(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=>
            (out_valid && $stable({out_type, out_opcode, out_funct3, out_funct7, out_rd,
                                   out_rs1_data, out_rs2_data, out_imm, out_illegal}))
    ) else $error("output slot changed while stalled");

endmodule

// File: test/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;
    logic        clk, rst, instr_valid, instr_ready, wb_en, out_valid, out_ready, out_illegal;
    logic [31:0] instr, wb_data, out_rs1_data, out_rs2_data, out_imm;
    logic [4:0]  wb_index, out_rd;
    logic [2:0]  out_type, out_funct3;
    logic [6:0]  out_opcode, out_funct7;
    logic [31:0] seed;
    logic [31:0] shadow [32];

    // bits 6:2 of every opcode in the table
    localparam logic [4:0] opcode_list [13] = '{5'b00000, 5'b00001, 5'b00100, 5'b00110,
        5'b11001, 5'b11000, 5'b01000, 5'b01001, 5'b00101, 5'b01101, 5'b11011, 5'b01100, 5'b10100};

    decode_stage i_decode_stage (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function logic [31:0] random_instr(input logic [4:0] op);
        logic [31:0] r;
        r = next_rand();
        return {r[31:7], op, 2'b11};
    endfunction

    function logic [2:0] classify(input logic [31:0] w);
        if (w[1:0] != 2'b11) return 3'd7;
        case (w[6:2])
            5'b00000, 5'b00001, 5'b00100, 5'b00110, 5'b11001: return 3'd0;
            5'b11000: return 3'd1;
            5'b01000, 5'b01001: return 3'd2;
            5'b00101, 5'b01101: return 3'd3;
            5'b11011: return 3'd4;
            5'b01100, 5'b10100: return 3'd5;
            default: return 3'd7;
        endcase
    endfunction

    function logic [31:0] assemble_imm(input logic [31:0] w);
        case (classify(w))
            3'd0: return {{20{w[31]}}, w[31:20]};
            3'd1: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            3'd2: return {{20{w[31]}}, w[31:25], w[11:7]};
            3'd3: return {w[31:12], 12'b0};
            3'd4: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default: return 32'b0;
        endcase
    endfunction

    task check_equal(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("Fail at %0t: %s, got %h expected %h", $time, msg, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task give_up(input string what);
        $display("timed out at %0t while waiting for %s", $time, what);
        $display("CHECKS FAILED");
        $fatal(1, "wait timed out");
    endtask

    task compare_out(input logic [31:0] w);
        logic [2:0] t;
        t = classify(w);
        check_equal(32'(out_type), 32'(t), "out_type");
        check_equal(32'(out_opcode), 32'(w[6:0]), "out_opcode");
        check_equal(32'(out_funct3), 32'(w[14:12]), "out_funct3");
        check_equal(32'(out_funct7), 32'(w[31:25]), "out_funct7");
        check_equal(32'(out_rd), 32'(w[11:7]), "out_rd");
        check_equal(out_imm, assemble_imm(w), "out_imm");
        check_equal(out_rs1_data, shadow[w[19:15]], "out_rs1_data");
        check_equal(out_rs2_data, shadow[w[24:20]], "out_rs2_data");
        check_equal(32'(out_illegal), 32'(t == 3'd7), "out_illegal");
    endtask

    task send_instr(input logic [31:0] w);
        int n;
        n = 0;
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= w;
        @(negedge clk);
        while (!instr_ready) begin
            n++;
            if (n > 20) give_up("instr_ready");
            @(negedge clk);
        end
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    // out_valid is due on the first cycle after the accepting edge
    task expect_out(input logic [31:0] w);
        int n;
        n = 0;
        @(negedge clk);
        while (!out_valid) begin
            n++;
            if (n > 20) give_up("out_valid");
            @(negedge clk);
        end
        check_equal(32'(n), 32'd0, "cycles from accept to out_valid");
        compare_out(w);
        @(posedge clk);
    endtask

    task write_reg(input logic [4:0] idx, input logic [31:0] data);
        @(posedge clk);
        wb_en    <= 1'b1;
        wb_index <= idx;
        wb_data  <= data;
        @(posedge clk);
        wb_en <= 1'b0;
        if (idx != 5'd0) shadow[idx] = data;
    endtask

    task formats_and_fields();
        logic [31:0] w;
        for (int k = 0; k < 39; k++) begin
            w = random_instr(opcode_list[k % 13]);
            send_instr(w);
            expect_out(w);
        end
    endtask

    task register_reads();
        logic [31:0] w;
        for (int i = 0; i < 32; i++) write_reg(5'(i), next_rand());
        for (int k = 0; k < 20; k++) begin
            w = random_instr(5'b01100);
            send_instr(w);
            expect_out(w);
        end
        // both sources on x0 after the x0 write
        w = random_instr(5'b01100);
        w[24:15] = 10'b0;
        send_instr(w);
        expect_out(w);
    endtask

    task write_through();
        logic [31:0] w, v;
        w = random_instr(5'b01100);
        w[15] = 1'b1;
        v = next_rand();
        @(posedge clk);
        wb_en       <= 1'b1;
        wb_index    <= w[19:15];
        wb_data     <= v;
        instr_valid <= 1'b1;
        instr       <= w;
        // slot is empty and this edge accepts
        @(posedge clk);
        wb_en       <= 1'b0;
        instr_valid <= 1'b0;
        shadow[w[19:15]] = v;
        expect_out(w);
    endtask

    task illegal_encodings();
        logic [31:0] w;
        w = random_instr(5'b00010);
        send_instr(w);
        expect_out(w);
        w = random_instr(5'b01100);
        w[1:0] = 2'b01;
        send_instr(w);
        expect_out(w);
    endtask

    task back_pressure();
        logic [31:0] w0, w1;
        w0 = random_instr(5'b00000);
        w1 = random_instr(5'b11000);
        @(posedge clk);
        out_ready <= 1'b0;
        send_instr(w0);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= w1;
        for (int k = 0; k < 5; k++) begin
            @(negedge clk);
            check_equal(32'(instr_ready), 32'd0, "instr_ready while stalled");
            check_equal(32'(out_valid), 32'd1, "out_valid while stalled");
            compare_out(w0);
            @(posedge clk);
        end
        out_ready <= 1'b1;
        // w0 leaves and w1 enters on this edge
        @(posedge clk);
        instr_valid <= 1'b0;
        expect_out(w1);
    endtask

    initial begin
        seed        = 32'd95086;
        rst         = 1'b1;
        instr_valid = 1'b0;
        instr       = 32'b0;
        wb_en       = 1'b0;
        wb_index    = 5'b0;
        wb_data     = 32'b0;
        out_ready   = 1'b1;
        for (int i = 0; i < 32; i++) shadow[i] = 32'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_equal(32'(out_valid), 32'd0, "out_valid after reset");
        check_equal(32'(instr_ready), 32'd1, "instr_ready after reset");
        formats_and_fields();
        register_reads();
        write_through();
        illegal_encodings();
        back_pressure();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: decode_stage.f
hdl/rv_decode_pkg.sv
hdl/decode_fields_if.sv
hdl/instruction_decoder.sv
hdl/immediate_generator.sv
hdl/register_file.sv
hdl/decode_stage.sv
test/decode_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module decode_stage_tb -f decode_stage.f -o decode_stage_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/decode_stage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "ALL CHECKS PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
